// ==== measure_bw.f ====
bw_pkg.sv
bw_regs.sv
rd_req_gen.sv
rd_data_sink.sv
measure_bw.sv
tb_axi_mem.sv
tb_measure_bw.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the measure_bw testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_measure_bw -f measure_bw.f -o sim_measure_bw
./obj_dir/sim_measure_bw > sim.log 2>&1
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi

// ==== tb_measure_bw.sv ====
`timescale 1ns/1ns

module tb_measure_bw;

    localparam logic [63:0] ADDR_OFFSET = 64'h0000_0040_0000_0000;
    localparam int          MAX_OUT     = 4;
    localparam int          WAIT_LIMIT  = 1000;

    logic        AXI_ACLK;
    logic        AXI_ARESETN;
    logic [4:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [4:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    bw_pkg::ar_req_t m_ar;
    logic            m_arvalid;
    logic            m_arready;
    logic            m_rvalid;
    logic            m_rlast;
    logic [1:0]      m_rresp;
    logic            m_rready;

    logic        stall_ar;
    logic        gap_r;
    logic        freeze = 1'b0;
    logic [31:0] ar_count;
    logic [31:0] done_count;

    logic [31:0] lfsr   = 32'd83957;
    int          errors = 0;
    int          checks = 0;
    bit          ended  = 1'b0;

    // Run timer of the testbench itself
    bit          armed      = 1'b0;
    bit          timing     = 1'b0;
    logic [31:0] run_target = '0;
    logic [63:0] run_cycles = '0;

    measure_bw #(
        .ADDRESS_OFFSET       (ADDR_OFFSET),
        .MAX_OUTSTANDING_RREQ (MAX_OUT),
        .AXI_DATA_WIDTH       (512)
    ) DUT (.*);

    tb_axi_mem u_mem (
        .clk        (AXI_ACLK),
        .rstn       (AXI_ARESETN),
        .ar         (m_ar),
        .arvalid    (m_arvalid),
        .arready    (m_arready),
        .rvalid     (m_rvalid),
        .rlast      (m_rlast),
        .rresp      (m_rresp),
        .rready     (m_rready),
        .stall_ar   (stall_ar),
        .gap_r      (gap_r),
        .ar_count   (ar_count),
        .done_count (done_count)
    );

    initial begin
        AXI_ACLK = 1'b0;
        forever #2 AXI_ACLK = ~AXI_ACLK;
    end

    // ========================================
    // Random bits and checking
    // ========================================
    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
        end
    endtask

    task automatic end_sim(input bit timed_out);
        if (!ended) begin
            ended = 1'b1;
            $display("Checks: %0d, errors: %0d", checks, errors);
            if ((errors == 0) && !timed_out) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    endtask

    // One cycle of a bounded wait sampled at the falling edge
    task automatic wait_step(inout int n, input string what);
        n++;
        if (n > WAIT_LIMIT) begin
            $display("Timed out waiting for %s", what);
            end_sim(1'b1);
        end
        @(negedge AXI_ACLK);
    endtask

    // ========================================
    // AXI4-Lite host
    // ========================================
    task automatic lite_write(input logic [3:0] idx, input logic [31:0] data,
                              output logic [1:0] resp);
        int n;
        @(posedge AXI_ACLK);
        awaddr  <= 5'({idx, 2'b00});
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        n = 0;
        @(negedge AXI_ACLK);
        while (!(awready && wready)) wait_step(n, "write address and data ready");
        @(posedge AXI_ACLK);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        @(negedge AXI_ACLK);
        while (!bvalid) wait_step(n, "write response");
        resp = bresp;
        // B handshake happens here as bready stays high
        @(posedge AXI_ACLK);
    endtask

    task automatic lite_read(input logic [3:0] idx, output logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        @(posedge AXI_ACLK);
        araddr  <= 5'({idx, 2'b00});
        arvalid <= 1'b1;
        n = 0;
        @(negedge AXI_ACLK);
        while (!arready) wait_step(n, "read address ready");
        @(posedge AXI_ACLK);
        arvalid <= 1'b0;
        n = 0;
        @(negedge AXI_ACLK);
        while (!rvalid) wait_step(n, "read data");
        data = rdata;
        resp = rresp;
        @(posedge AXI_ACLK);
    endtask

    // ========================================
    // Per-cycle monitor
    // ========================================
    always @(negedge AXI_ACLK) begin
        logic [31:0] b;
        if (AXI_ARESETN) begin
            check_equal(64'((ar_count - done_count) > MAX_OUT), 64'd0,
                        "bursts in flight within limit");
        end
        // Edges from first AR valid to the final RLAST handshake
        if (timing) begin
            if (done_count == run_target) begin
                timing = 1'b0;
            end else begin
                run_cycles = run_cycles + 64'd1;
            end
        end else if (armed && m_arvalid) begin
            armed      = 1'b0;
            timing     = 1'b1;
            run_cycles = '0;
        end
        // Roughly one stall in four on each channel
        draw_bits(2, b);
        stall_ar <= freeze | (&b[1:0]);
        draw_bits(2, b);
        gap_r    <= &b[1:0];
    end

    // ========================================
    // Tests
    // ========================================
    task automatic test_readback();
        logic [31:0] vals [4];
        logic [31:0] got;
        logic [1:0]  resp;
        for (int i = 0; i < 4; i++) begin
            draw_bits(32, vals[i]);
            lite_write(bw_pkg::REG_RADDR_H + 4'(i), vals[i], resp);
            check_equal(64'(resp), 64'd0, $sformatf("write response of word %0d", i));
        end
        for (int i = 0; i < 4; i++) begin
            lite_read(bw_pkg::REG_RADDR_H + 4'(i), got, resp);
            check_equal(64'(got), 64'(vals[i]), $sformatf("readback of word %0d", i));
            check_equal(64'(resp), 64'd0, $sformatf("read response of word %0d", i));
        end
    endtask

    task automatic test_unknown();
        logic [31:0] got;
        logic [1:0]  resp;
        // Offset 0x1C is word 7
        lite_write(4'd7, 32'hA5A5_5A5A, resp);
        check_equal(64'(resp), 64'd2, "write response of unknown offset");
        lite_read(4'd7, got, resp);
        check_equal(64'(resp), 64'd2, "read response of unknown offset");
        check_equal(64'(got), 64'h0DEC_0DE0, "read data of unknown offset");
    endtask

    task automatic test_run(input int run);
        logic [31:0]     hi;
        logic [31:0]     lo;
        logic [31:0]     rnd;
        logic [31:0]     cnt;
        logic [31:0]     blk;
        logic [31:0]     st;
        logic [31:0]     res_h;
        logic [31:0]     res_l;
        logic [1:0]      resp;
        logic [63:0]     exp_addr;
        bw_pkg::ar_req_t req;
        int              first;
        int              polls;
        draw_bits(32, hi);
        draw_bits(32, lo);
        draw_bits(4, rnd);
        cnt = (rnd % 12) + 32'd1;
        draw_bits(4, rnd);
        blk = (rnd + 32'd1) * 32'd64;
        lite_write(bw_pkg::REG_RADDR_H, hi, resp);
        lite_write(bw_pkg::REG_RADDR_L, lo, resp);
        lite_write(bw_pkg::REG_BLK_SIZE, blk, resp);
        lite_write(bw_pkg::REG_COUNT, cnt, resp);

        first      = int'(ar_count);
        run_target = done_count + cnt;
        armed      = 1'b1;
        // Hold AR off so the run is surely in progress at the status read
        freeze     = 1'b1;
        lite_write(bw_pkg::REG_CTL_STAT, 32'd1, resp);
        lite_read(bw_pkg::REG_CTL_STAT, st, resp);
        check_equal(64'(st[0]), 64'd1, $sformatf("run %0d status during run", run));
        freeze = 1'b0;

        polls = 0;
        while (st[0]) begin
            polls++;
            if (polls > WAIT_LIMIT) begin
                $display("Timed out waiting for run %0d to finish", run);
                end_sim(1'b1);
            end
            lite_read(bw_pkg::REG_CTL_STAT, st, resp);
        end

        lite_read(bw_pkg::REG_RRESULT_H, res_h, resp);
        lite_read(bw_pkg::REG_RRESULT_L, res_l, resp);
        check_equal({res_h, res_l}, run_cycles, $sformatf("run %0d elapsed cycles", run));
        check_equal(64'(int'(ar_count) - first), 64'(cnt),
                    $sformatf("run %0d request count", run));

        // Model of the AR sequence
        for (int i = 0; i < int'(cnt); i++) begin
            req      = u_mem.ar_log[first + i];
            exp_addr = {hi, lo} + ADDR_OFFSET + (64'(i) * 64'(blk));
            check_equal(req.addr, exp_addr, $sformatf("run %0d req %0d addr", run, i));
            check_equal(64'(req.id), 64'(i % 16), $sformatf("run %0d req %0d id", run, i));
            check_equal(64'(req.len), 64'((blk / 64) - 1),
                        $sformatf("run %0d req %0d len", run, i));
            check_equal(64'(req.size), 64'd6, $sformatf("run %0d req %0d size", run, i));
            check_equal(64'(req.burst), 64'd1, $sformatf("run %0d req %0d burst", run, i));
        end
    endtask

    task automatic test_refused();
        logic [31:0] st;
        logic [1:0]  resp;
        int          first;
        lite_write(bw_pkg::REG_COUNT, 32'd0, resp);
        first = int'(ar_count);
        lite_write(bw_pkg::REG_CTL_STAT, 32'd1, resp);
        for (int i = 0; i < 50; i++) begin
            @(negedge AXI_ACLK);
            check_equal(64'(m_arvalid), 64'd0, "AR valid after refused start");
        end
        check_equal(64'(int'(ar_count) - first), 64'd0, "requests after refused start");
        lite_read(bw_pkg::REG_CTL_STAT, st, resp);
        check_equal(64'(st[0]), 64'd0, "status after refused start");
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        AXI_ARESETN = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        bready      = 1'b1;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b1;
        stall_ar    = 1'b0;
        gap_r       = 1'b0;
        repeat (4) @(posedge AXI_ACLK);
        AXI_ARESETN <= 1'b1;

        test_readback();
        test_unknown();
        for (int r = 0; r < 3; r++) begin
            test_run(r);
        end
        test_refused();
        end_sim(1'b0);
    end

endmodule

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ns

module tb_axi_mem (
    input  logic            clk,
    input  logic            rstn,

    // AR channel from the DUT
    input  bw_pkg::ar_req_t ar,
    input  logic            arvalid,
    output logic            arready,

    // R channel towards the DUT, data payload omitted
    output logic            rvalid,
    output logic            rlast,
    output logic [1:0]      rresp,
    input  logic            rready,

    // Random back-pressure from the testbench top
    input  logic            stall_ar,
    input  logic            gap_r,

    output logic [31:0]     ar_count,
    output logic [31:0]     done_count
);

    // Every accepted request, in order of acceptance
    bw_pkg::ar_req_t ar_log[$];

    // Beats minus one of each burst still waiting for data
    logic [7:0] pend_len[$];
    logic [7:0] beat;
    logic       r_fire;

    initial begin
        arready    = 1'b0;
        rvalid     = 1'b0;
        rlast      = 1'b0;
        rresp      = 2'b00;
        ar_count   = '0;
        done_count = '0;
        beat       = '0;
    end

    // ========================================
    // Request queue and beat return
    // ========================================
    always @(posedge clk) begin
        if (!rstn) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rlast      <= 1'b0;
            rresp      <= 2'b00;
            ar_count   <= '0;
            done_count <= '0;
            beat        = '0;
            pend_len.delete();
            ar_log.delete();
        end else begin
            // Log the request seen at this edge
            if (arvalid && arready) begin
                ar_log.push_back(ar);
                pend_len.push_back(ar.len);
                ar_count <= ar_count + 32'd1;
            end

            r_fire = rvalid && rready;
            if (r_fire) begin
                if (rlast) begin
                    // Burst complete, oldest request retires
                    void'(pend_len.pop_front());
                    beat        = '0;
                    done_count <= done_count + 32'd1;
                end else begin
                    beat = beat + 8'd1;
                end
            end

            // A beat offered but not taken stays on the bus
            if (rvalid && !r_fire) begin
                rvalid <= 1'b1;
            end else if ((pend_len.size() > 0) && !gap_r) begin
                rvalid <= 1'b1;
                rlast  <= (beat == pend_len[0]);
            end else begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
            end
            rresp   <= 2'b00;
            arready <= !stall_ar;
        end
    end

endmodule

// ==== measure_bw.sv ====
`timescale 1ns/1ns

module measure_bw #(
    parameter logic [63:0] ADDRESS_OFFSET       = 64'h0,
    parameter int          MAX_OUTSTANDING_RREQ = 8,
    parameter int          AXI_DATA_WIDTH       = 512
) (
    input  logic                        AXI_ACLK,
    input  logic                        AXI_ARESETN,

    // AXI4-Lite control port
    input  logic [bw_pkg::S_ADDR_W-1:0] awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [bw_pkg::S_DATA_W-1:0] wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [bw_pkg::S_ADDR_W-1:0] araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [bw_pkg::S_DATA_W-1:0] rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,

    // AXI4 master read port under measurement
    output bw_pkg::ar_req_t             m_ar,
    output logic                        m_arvalid,
    input  logic                        m_arready,
    input  logic                        m_rvalid,
    input  logic                        m_rlast,
    input  logic [1:0]                  m_rresp,
    output logic                        m_rready
);

    logic            start;
    bw_pkg::rd_cfg_t cfg;
    logic [31:0]     blocks_done;
    logic            busy_req;
    logic            busy_sink;
    logic [63:0]     elapsed;

    // ========================================
    // Register block
    // ========================================
    bw_regs #(
        .AXI_DATA_WIDTH (AXI_DATA_WIDTH)
    ) u_regs (
        .AXI_ACLK    (AXI_ACLK),
        .AXI_ARESETN (AXI_ARESETN),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .eng_busy    ({busy_req, busy_sink}),
        .elapsed     (elapsed),
        .start       (start),
        .cfg         (cfg)
    );

    // ========================================
    // Read engines
    // ========================================
    rd_req_gen #(
        .ADDRESS_OFFSET       (ADDRESS_OFFSET),
        .MAX_OUTSTANDING_RREQ (MAX_OUTSTANDING_RREQ),
        .AXI_DATA_WIDTH       (AXI_DATA_WIDTH)
    ) u_req_gen (
        .AXI_ACLK    (AXI_ACLK),
        .AXI_ARESETN (AXI_ARESETN),
        .start       (start),
        .cfg         (cfg),
        .blocks_done (blocks_done),
        .m_ar        (m_ar),
        .m_arvalid   (m_arvalid),
        .m_arready   (m_arready),
        .busy        (busy_req)
    );

    // Completed bursts feed back to the request limit
    rd_data_sink u_sink (
        .AXI_ACLK    (AXI_ACLK),
        .AXI_ARESETN (AXI_ARESETN),
        .start       (start),
        .cfg         (cfg),
        .m_rvalid    (m_rvalid),
        .m_rlast     (m_rlast),
        .m_rresp     (m_rresp),
        .m_rready    (m_rready),
        .blocks_done (blocks_done),
        .busy        (busy_sink),
        .elapsed     (elapsed)
    );

endmodule

// ==== rd_data_sink.sv ====
`timescale 1ns/1ns

module rd_data_sink (
    input  logic            AXI_ACLK,
    input  logic            AXI_ARESETN,
    input  logic            start,
    input  bw_pkg::rd_cfg_t cfg,
    input  logic            m_rvalid,
    input  logic            m_rlast,
    input  logic [1:0]      m_rresp,
    output logic            m_rready,
    output logic [31:0]     blocks_done,
    output logic            busy,
    output logic [63:0]     elapsed
);

    bw_pkg::eng_state_e state;
    logic [63:0]        cycle_cnt;
    logic               burst_end;

    // Always ready while a run is active
    assign m_rready = (state == bw_pkg::ENG_RUN);
    assign busy     = (state == bw_pkg::ENG_RUN);

    // Response code is ignored, every burst counts as complete
    assign burst_end = m_rvalid & m_rready & m_rlast;

    // ========================================
    // Burst counter and run timer
    // ========================================
    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_ARESETN) begin
            state       <= bw_pkg::ENG_IDLE;
            blocks_done <= '0;
            cycle_cnt   <= '0;
            elapsed     <= '0;
        end else begin
            // Free running between starts
            cycle_cnt <= cycle_cnt + 64'd1;
            case (state)
                bw_pkg::ENG_IDLE: begin
                    if (start) begin
                        blocks_done <= '0;
                        cycle_cnt   <= '0;
                        state       <= bw_pkg::ENG_RUN;
                    end
                end
                bw_pkg::ENG_RUN: begin
                    if (burst_end) begin
                        blocks_done <= blocks_done + 32'd1;
                        // Final burst, keep the count from before this edge
                        if (blocks_done == cfg.last_index) begin
                            elapsed <= cycle_cnt;
                            state   <= bw_pkg::ENG_IDLE;
                        end
                    end
                end
                default: state <= bw_pkg::ENG_IDLE;
            endcase
        end
    end

endmodule

// ==== rd_req_gen.sv ====
`timescale 1ns/1ns

module rd_req_gen #(
    parameter logic [63:0] ADDRESS_OFFSET       = 64'h0,
    parameter int          MAX_OUTSTANDING_RREQ = 8,
    parameter int          AXI_DATA_WIDTH       = 512
) (
    input  logic            AXI_ACLK,
    input  logic            AXI_ARESETN,
    input  logic            start,
    input  bw_pkg::rd_cfg_t cfg,
    input  logic [31:0]     blocks_done,
    output bw_pkg::ar_req_t m_ar,
    output logic            m_arvalid,
    input  logic            m_arready,
    output logic            busy
);

    // Full-width beats, incrementing bursts
    localparam logic [2:0] AR_SIZE    = 3'($clog2(AXI_DATA_WIDTH / 8));
    localparam logic [1:0] BURST_INCR = 2'b01;

    bw_pkg::eng_state_e state;
    logic [63:0]        ar_addr;
    logic [3:0]         ar_id;
    logic [7:0]         ar_len;
    logic [31:0]        reqs_queued;
    logic               room;
    logic               ar_take;

    // Bursts in flight must stay below the limit
    assign room      = (reqs_queued - blocks_done) < 32'(MAX_OUTSTANDING_RREQ);
    assign m_arvalid = busy & room;
    assign ar_take   = m_arvalid & m_arready;
    assign busy      = (state == bw_pkg::ENG_RUN);

    always_comb begin
        m_ar.addr  = ar_addr;
        m_ar.id    = ar_id;
        m_ar.len   = ar_len;
        m_ar.size  = AR_SIZE;
        m_ar.burst = BURST_INCR;
    end

    // ========================================
    // Request FSM
    // ========================================
    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_ARESETN) begin
            state       <= bw_pkg::ENG_IDLE;
            reqs_queued <= '0;
        end else begin
            case (state)
                bw_pkg::ENG_IDLE: begin
                    if (start) begin
                        reqs_queued <= '0;
                        state       <= bw_pkg::ENG_RUN;
                    end
                end
                bw_pkg::ENG_RUN: begin
                    if (ar_take) begin
                        reqs_queued <= reqs_queued + 32'd1;
                        // Last block requested
                        if (reqs_queued == cfg.last_index) begin
                            state <= bw_pkg::ENG_IDLE;
                        end
                    end
                end
                default: state <= bw_pkg::ENG_IDLE;
            endcase
        end
    end

    // AR payload, held until accepted
    always_ff @(posedge AXI_ACLK) begin
        if (start && !busy) begin
            ar_addr <= cfg.base_addr + ADDRESS_OFFSET;
            ar_id   <= '0;
            ar_len  <= cfg.arlen;
        end else if (ar_take) begin
            ar_addr <= ar_addr + {32'd0, cfg.block_bytes};
            ar_id   <= ar_id + 4'd1;   // wraps at 16
        end
    end

endmodule

// ==== bw_regs.sv ====
`timescale 1ns/1ns

module bw_regs #(
    parameter int AXI_DATA_WIDTH = 512
) (
    input  logic                        AXI_ACLK,
    input  logic                        AXI_ARESETN,

    // AXI4-Lite write side
    input  logic [bw_pkg::S_ADDR_W-1:0] awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [bw_pkg::S_DATA_W-1:0] wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,

    // AXI4-Lite read side
    input  logic [bw_pkg::S_ADDR_W-1:0] araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [bw_pkg::S_DATA_W-1:0] rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,

    // Engine side
    input  logic [1:0]                  eng_busy,
    input  logic [63:0]                 elapsed,
    output logic                        start,
    output bw_pkg::rd_cfg_t             cfg
);

    // Beat size is a power of two, so beats per block is a shift
    localparam int BEAT_SHIFT = $clog2(AXI_DATA_WIDTH / 8);

    bw_pkg::lite_state_e         wr_state;
    bw_pkg::lite_state_e         rd_state;
    bw_pkg::resp_e               bresp_q;
    bw_pkg::resp_e               rresp_q;
    logic [bw_pkg::S_DATA_W-1:0] rdata_q;

    // Stored settings
    logic [bw_pkg::S_DATA_W-1:0] raddr_h;
    logic [bw_pkg::S_DATA_W-1:0] raddr_l;
    logic [bw_pkg::S_DATA_W-1:0] blk_size;
    logic [bw_pkg::S_DATA_W-1:0] count;

    logic [3:0] wr_idx;
    logic [3:0] rd_idx;
    logic       wr_take;
    logic       rd_take;
    logic       wr_known;
    logic       eng_idle;
    logic       start_ok;

    // ========================================
    // Handshakes and decode
    // ========================================
    assign awready = (wr_state == bw_pkg::LITE_IDLE);
    assign wready  = (wr_state == bw_pkg::LITE_IDLE);
    assign bvalid  = (wr_state == bw_pkg::LITE_RESP);
    assign bresp   = bresp_q;
    assign arready = (rd_state == bw_pkg::LITE_IDLE);
    assign rvalid  = (rd_state == bw_pkg::LITE_RESP);
    assign rdata   = rdata_q;
    assign rresp   = rresp_q;

    // Address and data must arrive together
    assign wr_take = awvalid & awready & wvalid & wready;
    assign rd_take = arvalid & arready;

    // Byte address to word index
    assign wr_idx = 4'(awaddr >> 2);
    assign rd_idx = 4'(araddr >> 2);

    // Writable words plus the control word
    assign wr_known = (wr_idx <= bw_pkg::REG_COUNT) || (wr_idx == bw_pkg::REG_CTL_STAT);

    assign eng_idle = ~|eng_busy;
    // Start only with both engines idle and a nonzero block count
    assign start_ok = wr_take && (wr_idx == bw_pkg::REG_CTL_STAT) && wdata[0]
                      && eng_idle && (count != '0);

    // ========================================
    // Write channel
    // ========================================
    always_ff @(posedge AXI_ACLK) begin
        // One-cycle pulse
        start <= 1'b0;
        if (!AXI_ARESETN) begin
            wr_state <= bw_pkg::LITE_IDLE;
            count    <= '0;
        end else begin
            case (wr_state)
                bw_pkg::LITE_IDLE: begin
                    if (wr_take) begin
                        wr_state <= bw_pkg::LITE_RESP;
                        if (wr_idx == bw_pkg::REG_COUNT) begin
                            count <= wdata;
                        end
                        start <= start_ok;
                    end
                end
                bw_pkg::LITE_RESP: begin
                    // Readies come back after the B handshake
                    if (bready) begin
                        wr_state <= bw_pkg::LITE_IDLE;
                    end
                end
                default: wr_state <= bw_pkg::LITE_IDLE;
            endcase
        end
    end

    // Settings, response and run snapshot
    always_ff @(posedge AXI_ACLK) begin
        if (wr_take) begin
            if (wr_known) begin
                bresp_q <= bw_pkg::RESP_OKAY;
            end else begin
                bresp_q <= bw_pkg::RESP_SLVERR;
            end
            case (wr_idx)
                bw_pkg::REG_RADDR_H:  raddr_h  <= wdata;
                bw_pkg::REG_RADDR_L:  raddr_l  <= wdata;
                bw_pkg::REG_BLK_SIZE: blk_size <= wdata;
                default: ;
            endcase
        end
        if (start_ok) begin
            cfg.base_addr   <= {raddr_h, raddr_l};
            cfg.block_bytes <= blk_size;
            cfg.last_index  <= count - 32'd1;
            cfg.arlen       <= 8'((blk_size >> BEAT_SHIFT) - 32'd1);
        end
    end

    // ========================================
    // Read channel
    // ========================================
    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_ARESETN) begin
            rd_state <= bw_pkg::LITE_IDLE;
        end else begin
            case (rd_state)
                bw_pkg::LITE_IDLE: if (rd_take) rd_state <= bw_pkg::LITE_RESP;
                bw_pkg::LITE_RESP: if (rready) rd_state <= bw_pkg::LITE_IDLE;
                default: rd_state <= bw_pkg::LITE_IDLE;
            endcase
        end
    end

    // Read data mux, sampled at the AR handshake
    always_ff @(posedge AXI_ACLK) begin
        if (rd_take) begin
            rresp_q <= bw_pkg::RESP_OKAY;
            case (rd_idx)
                bw_pkg::REG_RADDR_H:   rdata_q <= raddr_h;
                bw_pkg::REG_RADDR_L:   rdata_q <= raddr_l;
                bw_pkg::REG_BLK_SIZE:  rdata_q <= blk_size;
                bw_pkg::REG_COUNT:     rdata_q <= count;
                bw_pkg::REG_RRESULT_H: rdata_q <= elapsed[63:32];
                bw_pkg::REG_RRESULT_L: rdata_q <= elapsed[31:0];
                // Status bit 0 is run in progress
                bw_pkg::REG_CTL_STAT:  rdata_q <= {{(bw_pkg::S_DATA_W-1){1'b0}}, ~eng_idle};
                default: begin
                    rdata_q <= bw_pkg::BAD_REG_DATA;
                    rresp_q <= bw_pkg::RESP_SLVERR;
                end
            endcase
        end
    end

endmodule

// ==== bw_pkg.sv ====
package bw_pkg;

    // ========================================
    // Control port geometry and register map
    // ========================================
    localparam int S_ADDR_W = 5;
    localparam int S_DATA_W = 32;

    // Word indices, byte offset is four times these
    localparam logic [3:0] REG_RADDR_H   = 4'd0;
    localparam logic [3:0] REG_RADDR_L   = 4'd1;
    localparam logic [3:0] REG_BLK_SIZE  = 4'd2;
    localparam logic [3:0] REG_COUNT     = 4'd3;
    localparam logic [3:0] REG_RRESULT_H = 4'd4;
    localparam logic [3:0] REG_RRESULT_L = 4'd5;
    localparam logic [3:0] REG_CTL_STAT  = 4'd6;

    // Returned on a read of an unmapped word
    localparam logic [31:0] BAD_REG_DATA = 32'h0DEC_0DE0;

    // ========================================
    // Encodings
    // ========================================
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef enum logic {
        LITE_IDLE,
        LITE_RESP
    } lite_state_e;

    typedef enum logic {
        ENG_IDLE,
        ENG_RUN
    } eng_state_e;

    // ========================================
    // Bundles
    // ========================================
    // Run settings, frozen at start
    typedef struct packed {
        logic [63:0] base_addr;
        logic [31:0] block_bytes;
        logic [31:0] last_index;
        logic [7:0]  arlen;
    } rd_cfg_t;

    // AR channel payload
    typedef struct packed {
        logic [63:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } ar_req_t;

endpackage
